// File: src/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Bank index width
// 256 double-words per bank, two banks, 4 KiB of data memory
`define LSU_AW 8

// Rename bits appended to the 5-bit architectural register number
`define LSU_RNBIT 2

// Architectural register number width
// part of the destination tag
`define LSU_REGW 5

// Double-word offset inside a bank word, in address bits
// bits [2:0] pick the byte, bit 3 picks the bank
`define LSU_BANK_BIT 3

`endif

// File: src/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

	// Data and address word of the core
	typedef logic [63:0] xlen_t;

	// One double-word inside one bank
	typedef logic [`LSU_AW-1:0] bank_idx_t;

	// Byte write enables of one bank word
	typedef logic [7:0] byte_mask_t;

	// Destination register tag with rename bits
	typedef logic [`LSU_REGW+`LSU_RNBIT-1:0] rd_tag_t;

	// Access size code
	typedef logic [1:0] acc_size_t;

	// Byte offset inside a double-word
	typedef logic [2:0] lane_off_t;

	// 16-byte window spanning both banks
	typedef logic [127:0] win_t;

	// Byte enables over the 16-byte window
	typedef logic [15:0] win_mask_t;

	// Size codes as seen on lu_size and su_size
	localparam acc_size_t SZ_BYTE = 2'd0;
	localparam acc_size_t SZ_HALF = 2'd1;
	localparam acc_size_t SZ_WORD = 2'd2;
	localparam acc_size_t SZ_DWORD = 2'd3;

endpackage

// File: src/lsu_bank_if.sv
`timescale 1ns/1ps

// One port of a data memory bank
interface lsu_bank_if;

	// Double-word index inside the bank
	lsu_pkg::bank_idx_t idx;
	// Store data already moved to its lanes
	lsu_pkg::xlen_t wdata;
	// Write strobe, only for stores touching this bank
	logic wen;
	// Per-byte enables
	lsu_pkg::byte_mask_t wmask;
	// Registered read data, one cycle after idx
	lsu_pkg::xlen_t rdata;

	// Request side
	modport issue (
		output idx, wdata, wen, wmask,
		input rdata
	);

	// Memory side
	modport mem (
		input idx, wdata, wen, wmask,
		output rdata
	);

endinterface

// File: src/lsu_issue.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_issue (
	input logic CLK,
	input logic rst_n,

	// Load requests
	input logic lu_valid,
	output logic lu_ready,
	input lsu_pkg::xlen_t lu_addr,
	input lsu_pkg::acc_size_t lu_size,
	input logic lu_unsigned,
	input lsu_pkg::rd_tag_t lu_rd,

	// Store requests
	input logic su_valid,
	output logic su_ready,
	input lsu_pkg::xlen_t su_addr,
	input lsu_pkg::acc_size_t su_size,
	input lsu_pkg::xlen_t su_data,

	// Fences
	input logic fence_valid,
	output logic fence_ready,

	// Bank ports
	lsu_bank_if.issue bank_a,
	lsu_bank_if.issue bank_b,

	// Load context for writeback
	output logic op_done,
	output lsu_pkg::acc_size_t ld_size,
	output logic ld_unsigned,
	output lsu_pkg::lane_off_t ld_off,
	output logic ld_swap,
	output lsu_pkg::rd_tag_t ld_rd
);

	logic store_fire;
	logic load_fire;
	logic fence_fire;
	lsu_pkg::xlen_t acc_addr;
	lsu_pkg::bank_idx_t row;
	lsu_pkg::bank_idx_t row_inc;
	logic swap;
	lsu_pkg::lane_off_t off;
	lsu_pkg::win_mask_t base_mask;
	lsu_pkg::win_mask_t st_mask;
	lsu_pkg::win_t st_win;

	// Store wins over load, fence never collides
	assign store_fire = su_valid;
	assign load_fire = lu_valid & ~su_valid;
	assign fence_fire = fence_valid;

	assign su_ready = store_fire;
	assign lu_ready = load_fire;
	assign fence_ready = fence_fire;

	// Address of whichever access owns the banks this cycle
	assign acc_addr = store_fire ? su_addr : lu_addr;

	// Bank index is the dword number without its bank bit
	assign row = acc_addr[`LSU_BANK_BIT+1 +: `LSU_AW];
	// Wraps at the top of the bank
	assign row_inc = row + lsu_pkg::bank_idx_t'(1);
	// Odd dword first, so bank B holds the low half
	assign swap = acc_addr[`LSU_BANK_BIT];
	assign off = acc_addr[2:0];

	// Byte enables of the store before lane shifting
	always_comb begin
		case (su_size)
			lsu_pkg::SZ_BYTE: base_mask = 16'h0001;
			lsu_pkg::SZ_HALF: base_mask = 16'h0003;
			lsu_pkg::SZ_WORD: base_mask = 16'h000f;
			default: base_mask = 16'h00ff;
		endcase
	end

	// Spread over the 16-byte window
	assign st_mask = base_mask << off;
	assign st_win = {64'b0, su_data} << {off, 3'b000};

	// Low dword goes to bank A unless swapped
	assign bank_a.idx = swap ? row_inc : row;
	assign bank_b.idx = row;

	assign bank_a.wdata = swap ? st_win[127:64] : st_win[63:0];
	assign bank_b.wdata = swap ? st_win[63:0] : st_win[127:64];
	assign bank_a.wmask = swap ? st_mask[15:8] : st_mask[7:0];
	assign bank_b.wmask = swap ? st_mask[7:0] : st_mask[15:8];

	// Only banks that get at least one byte are written
	assign bank_a.wen = store_fire & (|bank_a.wmask);
	assign bank_b.wen = store_fire & (|bank_b.wmask);

	// One result slot per accepted operation
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			op_done <= 1'b0;
		end else begin
			op_done <= store_fire | load_fire | fence_fire;
		end
	end

	// Load context, held until the next load
	always_ff @(posedge CLK) begin
		if (load_fire) begin
			ld_size <= lu_size;
			ld_unsigned <= lu_unsigned;
			ld_off <= off;
			ld_swap <= swap;
		end
		// Stores and fences write back to x0
		ld_rd <= load_fire ? lu_rd : '0;
	end

	// Fence arrives alone
	a_fence_alone: assert property (@(posedge CLK) disable iff (!rst_n)
		fence_valid |-> !(lu_valid || su_valid));

	// Load held back by a store keeps asking
	a_load_held: assert property (@(posedge CLK) disable iff (!rst_n)
		(lu_valid && !lu_ready) |=> lu_valid);

endmodule

// File: src/dtcm.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module dtcm #(
	parameter int AW = `LSU_AW
) (
	input logic CLK,
	lsu_bank_if.mem port
);

	localparam int DEPTH = 2 ** AW;

	// Entry addressed this cycle
	logic [AW-1:0] row;
	// Bank storage, one double-word per entry
	lsu_pkg::xlen_t mem [DEPTH];
	lsu_pkg::xlen_t rdata_q;

	// Bank depth may differ from the index type
	assign row = AW'(port.idx);

	// Byte-wise write
	// read returns the old entry on a same-cycle write
	always_ff @(posedge CLK) begin
		if (port.wen) begin
			for (int i = 0; i < 8; i++) begin
				if (port.wmask[i]) begin
					mem[row][8*i +: 8] <= port.wdata[8*i +: 8];
				end
			end
		end
		rdata_q <= mem[row];
	end

	assign port.rdata = rdata_q;

	// Issue never strobes a bank without bytes to write
	a_wen_mask: assert property (@(posedge CLK)
		port.wen |-> (port.wmask != '0));

endmodule

// File: src/lsu_writeback.sv
`timescale 1ns/1ps

module lsu_writeback (
	input logic CLK,
	input logic rst_n,

	// Registered bank outputs
	input lsu_pkg::xlen_t bank_a_rdata,
	input lsu_pkg::xlen_t bank_b_rdata,

	// Load context from issue
	input logic op_done,
	input lsu_pkg::acc_size_t ld_size,
	input logic ld_unsigned,
	input lsu_pkg::lane_off_t ld_off,
	input logic ld_swap,
	input lsu_pkg::rd_tag_t ld_rd,

	// Writeback port
	output logic wb_valid,
	output lsu_pkg::xlen_t wb_res,
	output lsu_pkg::rd_tag_t wb_rd
);

	lsu_pkg::win_t window;
	lsu_pkg::win_t shifted;
	lsu_pkg::xlen_t raw;
	lsu_pkg::xlen_t size_mask;
	logic top_bit;
	logic sign_fill;

	// Rebuild the 16-byte window, low dword at the bottom
	assign window = ld_swap ? {bank_a_rdata, bank_b_rdata} : {bank_b_rdata, bank_a_rdata};

	// First addressed byte down to lane 0
	assign shifted = window >> {ld_off, 3'b000};
	assign raw = shifted[63:0];

	// Size mask and its top bit
	always_comb begin
		case (ld_size)
			lsu_pkg::SZ_BYTE: begin
				size_mask = 64'h0000_0000_0000_00ff;
				top_bit = raw[7];
			end
			lsu_pkg::SZ_HALF: begin
				size_mask = 64'h0000_0000_0000_ffff;
				top_bit = raw[15];
			end
			lsu_pkg::SZ_WORD: begin
				size_mask = 64'h0000_0000_ffff_ffff;
				top_bit = raw[31];
			end
			default: begin
				size_mask = '1;
				top_bit = raw[63];
			end
		endcase
	end

	// Signed loads fill above the access with the top bit
	assign sign_fill = ~ld_unsigned & top_bit;

	// Double loads have no bits above the mask
	assign wb_res = (raw & size_mask) | ({64{sign_fill}} & ~size_mask);

	// Single-cycle path, no back-pressure
	assign wb_valid = op_done;
	assign wb_rd = ld_rd;

	// A nonzero tag only comes with a result
	a_rd_valid: assert property (@(posedge CLK) disable iff (!rst_n)
		(wb_rd != '0) |-> wb_valid);

endmodule

// File: src/lsu.sv
`timescale 1ns/1ps

module lsu (
	input logic CLK,
	input logic rst_n,

	// Loads
	input logic lu_valid,
	output logic lu_ready,
	input lsu_pkg::xlen_t lu_addr,
	input lsu_pkg::acc_size_t lu_size,
	input logic lu_unsigned,
	input lsu_pkg::rd_tag_t lu_rd,

	// Stores
	input logic su_valid,
	output logic su_ready,
	input lsu_pkg::xlen_t su_addr,
	input lsu_pkg::acc_size_t su_size,
	input lsu_pkg::xlen_t su_data,

	// Fences
	input logic fence_valid,
	output logic fence_ready,

	// Writeback
	output logic wb_valid,
	output lsu_pkg::xlen_t wb_res,
	output lsu_pkg::rd_tag_t wb_rd
);

	// Even and odd double-word banks
	lsu_bank_if bank_a ();
	lsu_bank_if bank_b ();

	// Load context between issue and writeback
	logic op_done;
	lsu_pkg::acc_size_t ld_size;
	logic ld_unsigned;
	lsu_pkg::lane_off_t ld_off;
	logic ld_swap;
	lsu_pkg::rd_tag_t ld_rd;

	lsu_issue issue_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.lu_valid(lu_valid),
		.lu_ready(lu_ready),
		.lu_addr(lu_addr),
		.lu_size(lu_size),
		.lu_unsigned(lu_unsigned),
		.lu_rd(lu_rd),
		.su_valid(su_valid),
		.su_ready(su_ready),
		.su_addr(su_addr),
		.su_size(su_size),
		.su_data(su_data),
		.fence_valid(fence_valid),
		.fence_ready(fence_ready),
		.bank_a(bank_a.issue),
		.bank_b(bank_b.issue),
		.op_done(op_done),
		.ld_size(ld_size),
		.ld_unsigned(ld_unsigned),
		.ld_off(ld_off),
		.ld_swap(ld_swap),
		.ld_rd(ld_rd)
	);

	// Bank A, even double-words
	dtcm dtcm_a (
		.CLK(CLK),
		.port(bank_a.mem)
	);

	// Bank B, odd double-words
	dtcm dtcm_b (
		.CLK(CLK),
		.port(bank_b.mem)
	);

	lsu_writeback writeback_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.bank_a_rdata(bank_a.rdata),
		.bank_b_rdata(bank_b.rdata),
		.op_done(op_done),
		.ld_size(ld_size),
		.ld_unsigned(ld_unsigned),
		.ld_off(ld_off),
		.ld_swap(ld_swap),
		.ld_rd(ld_rd),
		.wb_valid(wb_valid),
		.wb_res(wb_res),
		.wb_rd(wb_rd)
	);

endmodule

// File: testbench/lsu_tb.sv
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_tb;

	localparam int CLK_PERIOD = 10;
	// Two banks of 2**AW double-words
	localparam int MEM_BYTES = 16 << `LSU_AW;
	// Cycles a request may wait for ready
	localparam int HS_LIMIT = 4;
	// Reset, dword, fill, sizes, misaligned, priority, fence, random
	localparam int TEST_CYCLES = 11 + 4 + 512 + 50 + 30 + 3 + 5 + 300;
	localparam int WATCHDOG_NS = (TEST_CYCLES + TEST_CYCLES / 4) * CLK_PERIOD;

	// Misaligned store cases, bank bit at 0 and 1, last one wraps
	localparam lsu_pkg::xlen_t MIS_ADDR [5] = '{64'h305, 64'h30d, 64'h31e, 64'h327, 64'hffb};
	localparam lsu_pkg::acc_size_t MIS_SIZE [5] = '{2'd3, 2'd3, 2'd2, 2'd1, 2'd3};

	// Byte address inside the data memory, wraps like the banks
	typedef logic [`LSU_AW+3:0] byte_addr_t;

	logic CLK = 1'b0;
	logic rst_n;
	logic lu_valid;
	logic lu_ready;
	lsu_pkg::xlen_t lu_addr;
	lsu_pkg::acc_size_t lu_size;
	logic lu_unsigned;
	lsu_pkg::rd_tag_t lu_rd;
	logic su_valid;
	logic su_ready;
	lsu_pkg::xlen_t su_addr;
	lsu_pkg::acc_size_t su_size;
	lsu_pkg::xlen_t su_data;
	logic fence_valid;
	logic fence_ready;
	logic wb_valid;
	lsu_pkg::xlen_t wb_res;
	lsu_pkg::rd_tag_t wb_rd;

	// Reference byte memory
	logic [7:0] mem_model [MEM_BYTES];
	logic [31:0] lfsr = 32'hdc725ec5;
	// Something transferred in the last tick
	logic fired;

	lsu lsu_inst (
		.CLK(CLK), .rst_n(rst_n),
		.lu_valid(lu_valid), .lu_ready(lu_ready), .lu_addr(lu_addr),
		.lu_size(lu_size), .lu_unsigned(lu_unsigned), .lu_rd(lu_rd),
		.su_valid(su_valid), .su_ready(su_ready), .su_addr(su_addr),
		.su_size(su_size), .su_data(su_data),
		.fence_valid(fence_valid), .fence_ready(fence_ready),
		.wb_valid(wb_valid), .wb_res(wb_res), .wb_rd(wb_rd)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic lsu_pkg::xlen_t take_bits(input int n);
		lsu_pkg::xlen_t val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[62:0], fb};
		end
		return val;
	endfunction

	function automatic void model_store(input lsu_pkg::xlen_t addr,
			input lsu_pkg::acc_size_t size, input lsu_pkg::xlen_t data);
		int nbytes;
		nbytes = 1 << size;
		for (int i = 0; i < nbytes; i++) begin
			mem_model[byte_addr_t'(addr + 64'(i))] = data[8*i +: 8];
		end
	endfunction

	// Little-endian gather, then zero or sign fill above the access
	function automatic lsu_pkg::xlen_t model_load(input lsu_pkg::xlen_t addr,
			input lsu_pkg::acc_size_t size, input logic uns);
		int nbytes;
		lsu_pkg::xlen_t val;
		nbytes = 1 << size;
		val = '0;
		for (int i = 0; i < nbytes; i++) begin
			val[8*i +: 8] = mem_model[byte_addr_t'(addr + 64'(i))];
		end
		if (!uns && val[8*nbytes-1]) begin
			for (int i = 8 * nbytes; i < 64; i++) begin
				val[i] = 1'b1;
			end
		end
		return val;
	endfunction

	// Fill value, distinct for every double-word
	function automatic lsu_pkg::xlen_t fill_word(input int k);
		return {16'(k) ^ 16'hc3a5, 16'(k * 7), ~16'(k), 16'(k) + 16'h1f00};
	endfunction

	task automatic check_val(input string test, input string what,
			input lsu_pkg::xlen_t exp, input lsu_pkg::xlen_t act);
		if (act !== exp) begin
			$display("ERROR %s %s expected %h actual %h", test, what, exp, act);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// One cycle from a falling edge to the next
	// writeback checked half a cycle after the accepting edge
	task automatic tick(input string name);
		logic st_fire;
		logic ld_fire;
		logic fn_fire;
		lsu_pkg::xlen_t exp_res;
		lsu_pkg::rd_tag_t exp_rd;
		#1;
		// Ready rules, store before load
		check_val(name, "su_ready", 64'(su_valid), 64'(su_ready));
		check_val(name, "lu_ready", 64'(lu_valid & ~su_valid), 64'(lu_ready));
		check_val(name, "fence_ready", 64'(fence_valid), 64'(fence_ready));
		st_fire = su_valid & su_ready;
		ld_fire = lu_valid & lu_ready;
		fn_fire = fence_valid & fence_ready;
		exp_res = '0;
		exp_rd = '0;
		if (ld_fire) begin
			exp_res = model_load(lu_addr, lu_size, lu_unsigned);
			exp_rd = lu_rd;
		end
		if (st_fire) begin
			model_store(su_addr, su_size, su_data);
		end
		fired = st_fire | ld_fire | fn_fire;
		@(negedge CLK);
		check_val(name, "wb_valid", 64'(fired), 64'(wb_valid));
		check_val(name, "wb_rd", 64'(exp_rd), 64'(wb_rd));
		if (ld_fire) begin
			check_val(name, "wb_res", exp_res, wb_res);
		end
	endtask

	task automatic wait_accept(input string name);
		int waited;
		waited = 0;
		tick(name);
		while (!fired) begin
			waited++;
			if (waited > HS_LIMIT) begin
				$display("%s: request not accepted within %0d cycles", name, HS_LIMIT);
				$display("TEST FAIL");
				$fatal(1, "handshake timeout");
			end
			tick(name);
		end
	endtask

	task automatic do_store(input string name, input lsu_pkg::xlen_t addr,
			input lsu_pkg::acc_size_t size, input lsu_pkg::xlen_t data);
		su_valid = 1'b1;
		su_addr = addr;
		su_size = size;
		su_data = data;
		wait_accept(name);
		su_valid = 1'b0;
	endtask

	task automatic do_load(input string name, input lsu_pkg::xlen_t addr,
			input lsu_pkg::acc_size_t size, input logic uns, input lsu_pkg::rd_tag_t rd);
		lu_valid = 1'b1;
		lu_addr = addr;
		lu_size = size;
		lu_unsigned = uns;
		lu_rd = rd;
		wait_accept(name);
		lu_valid = 1'b0;
	endtask

	task automatic test_reset_and_dword();
		// wb_valid stays low while reset is held
		repeat (10) begin
			@(negedge CLK);
			check_val("test_reset_and_dword", "wb_valid in reset", 64'd0, 64'(wb_valid));
		end
		rst_n = 1'b1;
		tick("test_reset_and_dword");
		// Even and odd aligned double-words
		do_store("test_reset_and_dword", 64'h100, lsu_pkg::SZ_DWORD, 64'h0123_4567_89ab_cdef);
		do_load("test_reset_and_dword", 64'h100, lsu_pkg::SZ_DWORD, 1'b0, 7'h2a);
		do_store("test_reset_and_dword", 64'h108, lsu_pkg::SZ_DWORD, 64'hfedc_ba98_7654_3210);
		do_load("test_reset_and_dword", 64'h108, lsu_pkg::SZ_DWORD, 1'b0, 7'h55);
	endtask

	// Banks power up undefined
	task automatic fill_memory();
		for (int k = 0; k < MEM_BYTES / 8; k++) begin
			do_store("fill_memory", 64'(k) << 3, lsu_pkg::SZ_DWORD, fill_word(k));
		end
	endtask

	task automatic test_sizes();
		do_store("test_sizes", 64'h200, lsu_pkg::SZ_DWORD, 64'hf08a_7f31_c4e2_5b96);
		do_store("test_sizes", 64'h208, lsu_pkg::SZ_DWORD, 64'h81ff_0017_a5c3_6e90);
		for (int off = 0; off < 8; off++) begin
			for (int sz = 0; sz < 3; sz++) begin
				for (int u = 0; u < 2; u++) begin
					do_load("test_sizes", 64'h200 + 64'(off), lsu_pkg::acc_size_t'(sz), u[0],
						lsu_pkg::rd_tag_t'(off * 6 + sz * 2 + u + 1));
				end
			end
		end
	endtask

	task automatic test_misaligned();
		lsu_pkg::xlen_t base;
		for (int c = 0; c < 5; c++) begin
			do_store("test_misaligned", MIS_ADDR[c], MIS_SIZE[c], take_bits(64));
			do_load("test_misaligned", MIS_ADDR[c], MIS_SIZE[c], 1'b0, 7'h11);
			// Neighbors on both sides, wrapping past the top
			base = MIS_ADDR[c] & ~64'h7;
			for (int d = -1; d < 3; d++) begin
				do_load("test_misaligned", base + 64'(d * 8), lsu_pkg::SZ_DWORD, 1'b1, 7'h12);
			end
		end
	endtask

	task automatic test_priority();
		lu_valid = 1'b1;
		lu_addr = 64'h400;
		lu_size = lsu_pkg::SZ_DWORD;
		lu_unsigned = 1'b0;
		lu_rd = 7'h33;
		su_valid = 1'b1;
		su_addr = 64'h404;
		su_size = lsu_pkg::SZ_WORD;
		su_data = 64'h0000_0000_8bad_f00d;
		#1;
		check_val("test_priority", "su_ready", 64'd1, 64'(su_ready));
		check_val("test_priority", "lu_ready", 64'd0, 64'(lu_ready));
		tick("test_priority");
		su_valid = 1'b0;
		// Held load goes next and sees the new word
		tick("test_priority");
		lu_valid = 1'b0;
	endtask

	task automatic test_fence();
		do_load("test_fence", 64'h500, lsu_pkg::SZ_DWORD, 1'b1, 7'h44);
		fence_valid = 1'b1;
		#1;
		check_val("test_fence", "fence_ready", 64'd1, 64'(fence_ready));
		tick("test_fence");
		fence_valid = 1'b0;
		do_load("test_fence", 64'h50c, lsu_pkg::SZ_HALF, 1'b0, 7'h45);
		// Idle cycle, no writeback
		tick("test_fence");
	endtask

	// Back-to-back loads and stores
	task automatic test_random();
		logic is_store;
		lsu_pkg::acc_size_t size;
		lsu_pkg::xlen_t addr;
		for (int n = 0; n < 300; n++) begin
			is_store = take_bits(1) != 0;
			size = lsu_pkg::acc_size_t'(take_bits(2));
			addr = take_bits(16);
			if (is_store) begin
				do_store("test_random", addr, size, take_bits(64));
			end else begin
				do_load("test_random", addr, size, take_bits(1) != 0,
					lsu_pkg::rd_tag_t'(take_bits(7)));
			end
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAIL");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		rst_n = 1'b0;
		lu_valid = 1'b0;
		lu_addr = '0;
		lu_size = '0;
		lu_unsigned = 1'b0;
		lu_rd = '0;
		su_valid = 1'b0;
		su_addr = '0;
		su_size = '0;
		su_data = '0;
		fence_valid = 1'b0;
		fired = 1'b0;
		test_reset_and_dword();
		fill_memory();
		test_sizes();
		test_misaligned();
		test_priority();
		test_fence();
		test_random();
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: sources.f
+incdir+src
src/lsu_pkg.sv
src/lsu_bank_if.sv
src/lsu_issue.sv
src/dtcm.sv
src/lsu_writeback.sv
src/lsu.sv
testbench/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module lsu_tb -o lsu_tb_sim \
	|| { echo "Verilator build failed"; exit 1; }

# The pass line in the simulator output decides the result
out="$(./obj_dir/lsu_tb_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
